//--- rtl/victim_pkg.sv
package victim_pkg;

    // ==================================================
    // geometry
    // ==================================================
    localparam int SLOT_COUNT       = 4;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_OFFSET_BITS = 5;  // 32-byte line.
    localparam int PADDR_BITS       = 32;
    localparam int BEAT_BITS        = 64;
    localparam int SLOT_IDX_BITS    = $clog2(SLOT_COUNT);
    localparam int BEAT_IDX_BITS    = $clog2(BEATS_PER_LINE);

    // fixed burst shape of one line write-back.
    localparam logic [7:0] WB_LEN        = 8'(BEATS_PER_LINE - 1);
    localparam logic [2:0] WB_SIZE       = 3'($clog2(BEAT_BITS / 8));
    localparam logic [1:0] WB_BURST_INCR = 2'b01;

    typedef logic [PADDR_BITS-1:0]                  paddr_t;
    typedef logic [PADDR_BITS-LINE_OFFSET_BITS-1:0] line_addr_t;
    typedef logic [BEAT_BITS-1:0]                   beat_t;
    typedef logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0] line_t;  // beat 0 sits at the lowest address.
    typedef logic [SLOT_IDX_BITS-1:0]               slot_idx_t;
    typedef logic [SLOT_COUNT-1:0]                  slot_mask_t;
    typedef logic [BEAT_IDX_BITS-1:0]               beat_idx_t;

    typedef enum logic [1:0] {IDLE, ADDRESS, WRITE, WAIT_RESP} wb_state_t;

    // snoop codes on the write address channel.
    typedef enum logic [2:0] {
        WRITE_CLEAN = 3'b010,
        WRITE_EVICT = 3'b100
    } wb_op_t;

    typedef struct packed {
        logic       line_valid;
        logic       dirty;
        line_addr_t addr;
        line_t      data;
    } victim_entry_t;

    typedef struct packed {
        paddr_t     addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        wb_op_t     op;
    } wb_aw_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } wb_w_t;

endpackage

//--- rtl/victim_store.sv
`timescale 1ns/100ps

module victim_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_en,
    input  victim_pkg::slot_mask_t  alloc_match,
    input  logic                    refill_en,
    input  victim_pkg::slot_idx_t   refill_idx,
    input  victim_pkg::victim_entry_t refill,
    input  logic                    release_en,
    input  victim_pkg::slot_idx_t   release_idx,
    input  logic                    snoop_remove,
    input  victim_pkg::slot_idx_t   snoop_remove_idx,
    output victim_pkg::victim_entry_t [victim_pkg::SLOT_COUNT-1:0] entries,
    output victim_pkg::slot_mask_t  busy_mask,
    output victim_pkg::slot_mask_t  data_valid_mask,
    output victim_pkg::slot_idx_t   free_idx,
    output logic                    full
);
    import victim_pkg::*;

    logic has_free;
    logic do_alloc;

    assign has_free = |(~busy_mask);
    assign do_alloc = alloc_en & ~(|alloc_match) & has_free;

    // ==================================================
    // free slot select
    // ==================================================
    // the loop runs downward so the lowest free slot wins.
    always_comb begin
        free_idx = '0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (!busy_mask[i]) begin
                free_idx = slot_idx_t'(i);
            end
        end
    end

    // ==================================================
    // slot flags
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_mask       <= '0;
            data_valid_mask <= '0;
        end else begin
            if (do_alloc) begin
                busy_mask[free_idx]       <= 1'b1;
                data_valid_mask[free_idx] <= 1'b0;  // the line arrives later with a fill.
            end
            if (refill_en) begin
                data_valid_mask[refill_idx] <= 1'b1;
            end
            // a release and a snoop removal can land on the same edge.
            if (release_en) begin
                busy_mask[release_idx] <= 1'b0;
            end
            if (snoop_remove) begin
                busy_mask[snoop_remove_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else begin
            full <= ~has_free;  // follows the flags by one cycle.
        end
    end

    // ==================================================
    // entry array
    // ==================================================
    always_ff @(posedge clk) begin
        if (refill_en) begin
            entries[refill_idx] <= refill;
        end
    end

endmodule

//--- rtl/victim_lookup.sv
`timescale 1ns/100ps

module victim_lookup (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_en,
    input  victim_pkg::paddr_t      waddr,
    input  logic                    snoop_en,
    input  logic                    snoop_clean,
    input  victim_pkg::paddr_t      snoop_addr,
    input  victim_pkg::victim_entry_t [victim_pkg::SLOT_COUNT-1:0] entries,
    input  victim_pkg::slot_mask_t  busy_mask,
    input  victim_pkg::slot_mask_t  data_valid_mask,
    input  victim_pkg::slot_idx_t   free_idx,
    input  logic                    refill_en,
    input  victim_pkg::slot_idx_t   refill_idx,
    input  victim_pkg::victim_entry_t refill,
    input  victim_pkg::slot_idx_t   active_idx,
    input  logic                    engine_busy,
    output victim_pkg::slot_mask_t  alloc_match,
    output logic                    alloc_hit,
    output victim_pkg::slot_idx_t   alloc_idx,
    output logic                    snoop_hit,
    output logic                    snoop_dirty,
    output victim_pkg::line_t       snoop_data,
    output logic                    snoop_remove,
    output victim_pkg::slot_idx_t   snoop_remove_idx
);
    import victim_pkg::*;

    paddr_t     cmp_addr;
    line_addr_t cmp_line;
    slot_idx_t  match_idx;
    logic       fill_hit;
    logic       any_hit;

    // a snoop takes over the comparator for its cycle.
    assign cmp_addr = snoop_en ? snoop_addr : waddr;
    assign cmp_line = cmp_addr[PADDR_BITS-1:LINE_OFFSET_BITS];

    always_comb begin
        for (int i = 0; i < SLOT_COUNT; i++) begin
            alloc_match[i] = busy_mask[i] & data_valid_mask[i] & entries[i].line_valid &
                             (entries[i].addr == cmp_line);
        end
    end

    always_comb begin
        match_idx = '0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (alloc_match[i]) begin
                match_idx = slot_idx_t'(i);
            end
        end
    end

    // a line being filled right now is not yet in the array.
    assign fill_hit = refill_en & refill.line_valid & (refill.addr == cmp_line);
    assign any_hit  = (|alloc_match) | fill_hit;

    assign snoop_remove_idx = fill_hit ? refill_idx : match_idx;
    assign snoop_remove     = snoop_en & snoop_clean & any_hit &
                              ~(engine_busy & (snoop_remove_idx == active_idx));

    // ==================================================
    // registered replies
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alloc_hit   <= 1'b0;
            alloc_idx   <= '0;
            snoop_hit   <= 1'b0;
            snoop_dirty <= 1'b0;
        end else begin
            if (alloc_en) begin
                alloc_hit <= |alloc_match;
                alloc_idx <= (|alloc_match) ? match_idx : free_idx;
            end
            if (snoop_en) begin
                snoop_hit   <= any_hit;
                snoop_dirty <= fill_hit ? refill.dirty : entries[match_idx].dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (snoop_en) begin
            snoop_data <= fill_hit ? refill.data : entries[match_idx].data;  // held until the next snoop.
        end
    end

endmodule

//--- rtl/writeback_engine.sv
`timescale 1ns/100ps

module writeback_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  victim_pkg::victim_entry_t [victim_pkg::SLOT_COUNT-1:0] entries,
    input  victim_pkg::slot_mask_t  busy_mask,
    input  victim_pkg::slot_mask_t  data_valid_mask,
    output victim_pkg::wb_aw_t      aw,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output victim_pkg::wb_w_t       w,
    output logic                    w_valid,
    input  logic                    w_ready,
    input  logic                    b_valid,
    output logic                    release_en,
    output victim_pkg::slot_idx_t   release_idx,
    output victim_pkg::slot_idx_t   active_idx,
    output logic                    engine_busy
);
    import victim_pkg::*;

    wb_state_t     state;
    slot_mask_t    ready_mask;
    slot_idx_t     pick_idx;
    slot_idx_t     cur_idx;
    victim_entry_t cur_entry;
    beat_idx_t     beat;
    logic          last_beat;

    assign ready_mask = busy_mask & data_valid_mask;

    always_comb begin
        pick_idx = '0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (ready_mask[i]) begin
                pick_idx = slot_idx_t'(i);
            end
        end
    end

    // while idle the candidate counts as in flight, so a snoop cannot remove it under us.
    assign engine_busy = (state != IDLE) | (|ready_mask);
    assign active_idx  = (state == IDLE) ? pick_idx : cur_idx;

    assign last_beat   = (beat == beat_idx_t'(BEATS_PER_LINE - 1));
    assign release_en  = (state == WAIT_RESP) & (b_valid | ~cur_entry.line_valid);
    assign release_idx = cur_idx;

    // ==================================================
    // write channel state machine
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            cur_idx  <= '0;
            beat     <= '0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (|ready_mask) begin
                        cur_idx <= pick_idx;
                        if (entries[pick_idx].line_valid) begin
                            aw_valid <= 1'b1;
                            state    <= ADDRESS;
                        end else begin
                            state <= WAIT_RESP;  // nothing to send.
                        end
                    end
                end
                ADDRESS: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b1;
                        beat     <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (w_ready) begin
                        if (last_beat) begin
                            w_valid <= 1'b0;
                            state   <= WAIT_RESP;
                        end else begin
                            beat <= beat + 2'd1;
                        end
                    end
                end
                WAIT_RESP: begin
                    if (release_en) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            cur_entry <= entries[pick_idx];
        end
    end

    always_comb begin
        aw.addr  = {cur_entry.addr, {LINE_OFFSET_BITS{1'b0}}};
        aw.len   = WB_LEN;
        aw.size  = WB_SIZE;
        aw.burst = WB_BURST_INCR;
        aw.op    = cur_entry.dirty ? WRITE_CLEAN : WRITE_EVICT;
        w.data   = cur_entry.data[beat];
        w.last   = last_beat;
    end

endmodule

//--- rtl/victim_buffer_top.sv
`timescale 1ns/100ps

module victim_buffer_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_en,
    input  victim_pkg::paddr_t        waddr,
    output logic                      alloc_hit,
    output victim_pkg::slot_idx_t     alloc_idx,
    input  logic                      refill_en,
    input  victim_pkg::slot_idx_t     refill_idx,
    input  victim_pkg::victim_entry_t refill,
    input  logic                      snoop_en,
    input  logic                      snoop_clean,
    input  victim_pkg::paddr_t        snoop_addr,
    output logic                      snoop_hit,
    output logic                      snoop_dirty,
    output victim_pkg::line_t         snoop_data,
    output logic                      full,
    output victim_pkg::wb_aw_t        aw,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    output victim_pkg::wb_w_t         w,
    output logic                      w_valid,
    input  logic                      w_ready,
    input  logic                      b_valid
);
    import victim_pkg::*;

    victim_entry_t [SLOT_COUNT-1:0] entries;
    slot_mask_t busy_mask;
    slot_mask_t data_valid_mask;
    slot_mask_t alloc_match;
    slot_idx_t  free_idx;
    slot_idx_t  release_idx;
    slot_idx_t  snoop_remove_idx;
    slot_idx_t  active_idx;
    logic       release_en;
    logic       snoop_remove;
    logic       engine_busy;

    victim_store u_store (
        .clk, .rst, .alloc_en, .alloc_match, .refill_en, .refill_idx, .refill,
        .release_en, .release_idx, .snoop_remove, .snoop_remove_idx,
        .entries, .busy_mask, .data_valid_mask, .free_idx, .full
    );

    victim_lookup u_lookup (
        .clk, .rst, .alloc_en, .waddr, .snoop_en, .snoop_clean, .snoop_addr,
        .entries, .busy_mask, .data_valid_mask, .free_idx,
        .refill_en, .refill_idx, .refill, .active_idx, .engine_busy,
        .alloc_match, .alloc_hit, .alloc_idx,
        .snoop_hit, .snoop_dirty, .snoop_data, .snoop_remove, .snoop_remove_idx
    );

    writeback_engine u_engine (
        .clk, .rst, .entries, .busy_mask, .data_valid_mask,
        .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready, .b_valid,
        .release_en, .release_idx, .active_idx, .engine_busy
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD_NS = 2;  // 4 ns period.

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

//--- testbench/victim_buffer_tb.sv
`timescale 1ns/100ps

module victim_buffer_tb;
    import victim_pkg::*;

    localparam int SEED            = 38680;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int TEST_COUNT      = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic          clk;
    logic          rst;
    logic          alloc_en;
    paddr_t        waddr;
    logic          alloc_hit;
    slot_idx_t     alloc_idx;
    logic          refill_en;
    slot_idx_t     refill_idx;
    victim_entry_t refill;
    logic          snoop_en;
    logic          snoop_clean;
    paddr_t        snoop_addr;
    logic          snoop_hit;
    logic          snoop_dirty;
    line_t         snoop_data;
    logic          full;
    wb_aw_t        aw;
    logic          aw_valid;
    logic          aw_ready;
    wb_w_t         w;
    logic          w_valid;
    logic          w_ready;
    logic          b_valid = 1'b0;

    int     errors = 0;
    int     bursts_done = 0;
    wb_aw_t aw_q[$];
    beat_t  beat_q[$];
    logic   last_q[$];

    tb_clock u_clock (.clk(clk));

    victim_buffer_top dut (.*);

    // ==================================================
    // write slave
    // ==================================================
    always @(posedge clk) begin
        b_valid <= 1'b0;
        if (aw_valid && aw_ready) begin
            aw_q.push_back(aw);
        end
        if (w_valid && w_ready) begin
            beat_q.push_back(w.data);
            last_q.push_back(w.last);
            if (w.last) begin
                b_valid <= 1'b1;  // response one cycle after the last beat.
            end
        end
        if (b_valid) begin
            bursts_done <= bursts_done + 1;
        end
    end

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_addr(input string name, input paddr_t exp, input paddr_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t exp, input beat_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input wb_op_t exp, input wb_op_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input slot_idx_t exp, input slot_idx_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_code(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            check_beat($sformatf("%s beat %0d", name, k), exp[k], act[k]);
        end
    endtask

    task automatic check_burst(input string name, input int aw_at, input int beat_at,
                               input paddr_t exp_addr, input wb_op_t exp_op,
                               input line_t exp_data);
        if (aw_q.size() <= aw_at || beat_q.size() < beat_at + BEATS_PER_LINE) begin
            $display("%s: the burst never reached the slave", name);
            errors++;
            return;
        end
        check_addr({name, " addr"}, exp_addr, aw_q[aw_at].addr);
        check_len({name, " len"}, 8'd3, aw_q[aw_at].len);
        check_code({name, " size"}, 3'd3, aw_q[aw_at].size);
        check_code({name, " burst"}, 3'd1, 3'(aw_q[aw_at].burst));
        check_op({name, " op"}, exp_op, aw_q[aw_at].op);
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            check_beat($sformatf("%s beat %0d", name, k), exp_data[k], beat_q[beat_at + k]);
            check_bit($sformatf("%s last %0d", name, k), k == BEATS_PER_LINE - 1,
                      last_q[beat_at + k]);
        end
    endtask

    // ==================================================
    // drivers
    // ==================================================
    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            l[k] = {$urandom(), $urandom()};
        end
        return l;
    endfunction

    function automatic victim_entry_t make_entry(input paddr_t addr, input logic dirty,
                                                 input logic valid, input line_t data);
        victim_entry_t e;
        e.line_valid = valid;
        e.dirty      = dirty;
        e.addr       = addr[PADDR_BITS-1:LINE_OFFSET_BITS];
        e.data       = data;
        return e;
    endfunction

    task automatic alloc_line(input paddr_t addr, output logic hit, output slot_idx_t idx);
        @(posedge clk);
        alloc_en <= 1'b1;
        waddr    <= addr;
        @(posedge clk);
        alloc_en <= 1'b0;
        @(negedge clk);  // reply registered on the edge that took the strobe.
        hit = alloc_hit;
        idx = alloc_idx;
    endtask

    task automatic fill_line(input slot_idx_t idx, input victim_entry_t e);
        @(posedge clk);
        refill_en  <= 1'b1;
        refill_idx <= idx;
        refill     <= e;
        @(posedge clk);
        refill_en <= 1'b0;
    endtask

    // an empty fill frees a reserved slot; the engine needs two cycles for it.
    task automatic release_empty(input slot_idx_t idx);
        fill_line(idx, make_entry('0, 1'b0, 1'b0, '0));
        repeat (4) @(posedge clk);
    endtask

    task automatic snoop_line(input paddr_t addr, input logic clean,
                              output logic hit, output logic dirty, output line_t data);
        @(posedge clk);
        snoop_en    <= 1'b1;
        snoop_clean <= clean;
        snoop_addr  <= addr;
        @(posedge clk);
        snoop_en <= 1'b0;
        @(negedge clk);
        hit   = snoop_hit;
        dirty = snoop_dirty;
        data  = snoop_data;
    endtask

    task automatic set_aw_ready(input logic value);
        @(posedge clk);
        aw_ready <= value;
    endtask

    task automatic set_w_ready(input logic value);
        @(posedge clk);
        w_ready <= value;
    endtask

    task automatic wait_bursts(input int target);
        int cycles;
        cycles = 0;
        while (bursts_done < target && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (bursts_done < target) begin
            $display("write response number %0d never arrived", target);
            errors++;
        end
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset_state();
        @(negedge clk);
        check_bit("reset full", 1'b0, full);
        check_bit("reset aw_valid", 1'b0, aw_valid);
        check_bit("reset w_valid", 1'b0, w_valid);
        check_bit("reset alloc_hit", 1'b0, alloc_hit);
        check_bit("reset snoop_hit", 1'b0, snoop_hit);
    endtask

    task automatic test_dirty_evict();
        line_t     data;
        logic      hit;
        slot_idx_t idx;
        int        aw_base;
        int        beat_base;
        data      = random_line();
        aw_base   = aw_q.size();
        beat_base = beat_q.size();
        alloc_line(32'h0001_2345, hit, idx);
        check_bit("dirty alloc hit", 1'b0, hit);
        check_idx("dirty alloc idx", 2'd0, idx);
        fill_line(idx, make_entry(32'h0001_2345, 1'b1, 1'b1, data));
        wait_bursts(bursts_done + 1);
        check_count("dirty burst count", 1, aw_q.size() - aw_base);
        check_burst("dirty burst", aw_base, beat_base, 32'h0001_2340, WRITE_CLEAN, data);
        alloc_line(32'h0002_0000, hit, idx);
        check_idx("dirty slot reuse", 2'd0, idx);
        release_empty(idx);
    endtask

    task automatic test_clean_and_empty();
        line_t     data;
        logic      hit;
        slot_idx_t idx;
        int        aw_base;
        data    = random_line();
        aw_base = aw_q.size();
        set_w_ready(1'b0);
        alloc_line(32'h0003_0008, hit, idx);
        fill_line(idx, make_entry(32'h0003_0008, 1'b0, 1'b1, data));
        repeat (8) @(posedge clk);  // the engine sits in the data phase meanwhile.
        set_w_ready(1'b1);
        wait_bursts(bursts_done + 1);
        check_burst("clean burst", aw_base, beat_q.size() - BEATS_PER_LINE,
                    32'h0003_0000, WRITE_EVICT, data);
        alloc_line(32'h0004_0000, hit, idx);
        check_idx("empty alloc idx", 2'd0, idx);
        release_empty(idx);
        check_count("empty line bursts", 1, aw_q.size() - aw_base);
        alloc_line(32'h0005_0000, hit, idx);
        check_idx("empty slot freed", 2'd0, idx);
        release_empty(idx);
    endtask

    task automatic test_hit_and_full();
        paddr_t    addrs[4];
        logic      hit;
        slot_idx_t idx;
        int        aw_base;
        int        done_base;
        addrs     = '{32'h0010_0000, 32'h0010_0020, 32'h0010_0040, 32'h0010_0060};
        aw_base   = aw_q.size();
        done_base = bursts_done;
        set_aw_ready(1'b0);
        alloc_line(addrs[0], hit, idx);
        fill_line(idx, make_entry(addrs[0], 1'b1, 1'b1, random_line()));
        alloc_line(addrs[0] + 32'h4, hit, idx);  // same line, different offset.
        check_bit("held line alloc hit", 1'b1, hit);
        check_idx("held line alloc idx", 2'd0, idx);
        for (int k = 1; k < SLOT_COUNT; k++) begin
            alloc_line(addrs[k], hit, idx);
            check_idx($sformatf("distinct alloc %0d idx", k), slot_idx_t'(k), idx);
        end
        @(negedge clk);
        check_bit("full after four allocations", 1'b1, full);
        for (int k = 1; k < SLOT_COUNT; k++) begin
            fill_line(slot_idx_t'(k), make_entry(addrs[k], k[0], 1'b1, random_line()));
        end
        set_aw_ready(1'b1);
        wait_bursts(done_base + SLOT_COUNT);
        check_count("drain burst count", SLOT_COUNT, aw_q.size() - aw_base);
        for (int k = 0; k < SLOT_COUNT && aw_base + k < aw_q.size(); k++) begin
            check_addr($sformatf("drain order %0d", k), addrs[k], aw_q[aw_base + k].addr);
        end
        @(negedge clk);
        check_bit("full after drain", 1'b0, full);
    endtask

    task automatic test_snoop();
        line_t     data_a;
        line_t     data_b;
        line_t     data_c;
        line_t     got;
        logic      hit;
        logic      dirty;
        slot_idx_t idx;
        int        aw_base;
        int        done_base;
        logic      removed_sent;
        data_a       = random_line();
        data_b       = random_line();
        data_c       = random_line();
        aw_base      = aw_q.size();
        done_base    = bursts_done;
        removed_sent = 1'b0;
        set_aw_ready(1'b0);
        alloc_line(32'h0020_0000, hit, idx);
        fill_line(idx, make_entry(32'h0020_0000, 1'b1, 1'b1, data_a));
        alloc_line(32'h0020_0100, hit, idx);
        fill_line(idx, make_entry(32'h0020_0100, 1'b0, 1'b1, data_b));
        snoop_line(32'h0020_0010, 1'b0, hit, dirty, got);
        check_bit("snoop held hit", 1'b1, hit);
        check_bit("snoop held dirty", 1'b1, dirty);
        check_line("snoop held data", data_a, got);
        snoop_line(32'h0020_0100, 1'b1, hit, dirty, got);  // slot 1 is not in flight.
        check_bit("snoop clean hit", 1'b1, hit);
        check_bit("snoop clean dirty", 1'b0, dirty);
        check_line("snoop clean data", data_b, got);
        alloc_line(32'h0020_0200, hit, idx);
        check_idx("slot after snoop removal", 2'd1, idx);
        // fill and snoop land on the same edge.
        @(posedge clk);
        refill_en   <= 1'b1;
        refill_idx  <= idx;
        refill      <= make_entry(32'h0020_0200, 1'b1, 1'b1, data_c);
        snoop_en    <= 1'b1;
        snoop_clean <= 1'b0;
        snoop_addr  <= 32'h0020_0200;
        @(posedge clk);
        refill_en <= 1'b0;
        snoop_en  <= 1'b0;
        @(negedge clk);
        check_bit("snoop with fill hit", 1'b1, snoop_hit);
        check_bit("snoop with fill dirty", 1'b1, snoop_dirty);
        check_line("snoop with fill data", data_c, snoop_data);
        snoop_line(32'h0030_0000, 1'b0, hit, dirty, got);
        check_bit("snoop unheld hit", 1'b0, hit);
        set_aw_ready(1'b1);
        wait_bursts(done_base + 2);
        check_count("snoop burst count", 2, aw_q.size() - aw_base);
        for (int k = aw_base; k < aw_q.size(); k++) begin
            if (aw_q[k].addr == 32'h0020_0100) begin
                removed_sent = 1'b1;
            end
        end
        check_bit("burst for removed line", 1'b0, removed_sent);
    endtask

    // ==================================================
    // run control
    // ==================================================
    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        alloc_en    = 1'b0;
        waddr       = '0;
        refill_en   = 1'b0;
        refill_idx  = '0;
        refill      = '0;
        snoop_en    = 1'b0;
        snoop_clean = 1'b0;
        snoop_addr  = '0;
        aw_ready    = 1'b1;
        w_ready     = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_dirty_evict();
        test_clean_and_empty();
        test_hit_and_full();
        test_snoop();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD_NS);
        $display("watchdog expired before the tests finished, errors so far: %0d", errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sources.f
rtl/victim_pkg.sv
rtl/victim_store.sv
rtl/victim_lookup.sv
rtl/writeback_engine.sv
rtl/victim_buffer_top.sv
testbench/tb_clock.sv
testbench/victim_buffer_tb.sv

//--- Makefile
TOP = victim_buffer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
